// ==== Bender.yml ====
package:
  name: kd_search

sources:
  # Package first, then the tree from the leaves up
  - logic/kdtree_pkg.sv
  - logic/kd_node.sv
  - logic/kd_node_loader.sv
  - logic/kd_tree_level.sv
  - logic/kd_search_tree.sv
  - logic/kd_search_top.sv

  # Testbench, top module kd_search_tb
  - target: any(simulation, test)
    files:
      - verification/kd_search_checker.sv
      - verification/kd_search_tb.sv

// ==== logic/kd_node.sv ====
`timescale 1ns/100ps

module kd_node
  import kdtree_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wen,      // One-hot select from the loader
  input  node_cfg_t cfg,
  input  query_t    patches,
  input  logic      valid_a,
  input  logic      valid_b,
  output logic      left_a,
  output logic      right_a,
  output logic      left_b,
  output logic      right_b
);

  dim_t   split_dim; // Stored split dimension
  coord_t median;    // Stored split value
  coord_t coord_a;   // Selected coordinate, lane a
  coord_t coord_b;   // Selected coordinate, lane b
  logic   less_a;
  logic   less_b;

  // Pick one coordinate out of a patch, invalid dims read as zero
  function automatic coord_t pick_coord(input patch_t p, input dim_t d);
    coord_t c;
    c = '0;
    if (int'(d) < NUM_DIMS) begin
      c = coord_t'(p[int'(d)*COORD_WIDTH +: COORD_WIDTH]);
    end
    return c;
  endfunction

  // Split storage, written once per tree load
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      split_dim <= DIM_INVALID; // Everything goes right until loaded
      median    <= '0;
    end else if (wen) begin
      split_dim <= cfg.dim_field[2:0]; // Upper bits of the field are spare
      median    <= cfg.median;
    end
  end

  assign coord_a = pick_coord(patches.patch_a, split_dim);
  assign coord_b = pick_coord(patches.patch_b, split_dim);

  // Both operands are signed so the compare is signed
  assign less_a = (coord_a < median);
  assign less_b = (coord_b < median);

  // Strictly less goes left, equal or greater goes right
  assign left_a  = valid_a & less_a;
  assign right_a = valid_a & ~less_a;
  assign left_b  = valid_b & less_b;
  assign right_b = valid_b & ~less_b;

endmodule

// ==== logic/kd_node_loader.sv ====
`timescale 1ns/100ps

module kd_node_loader
  import kdtree_pkg::*;
#(
  parameter int TREE_DEPTH = 6
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cfg_mode,   // Level from the host FSM
  input  logic                 cfg_strobe, // One pulse per config word
  output logic [MAX_NODES-1:0] node_sel    // One-hot write select
);

  // Address of the last internal node for the configured depth
  localparam node_addr_t LAST_ADDR = node_addr_t'(2**TREE_DEPTH - 2);

  node_addr_t wr_addr; // Next node to be written, breadth-first
  logic       wr_en;

  assign wr_en = cfg_mode & cfg_strobe;

  // Write counter, wraps so a second load starts again at the root
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (wr_en) begin
      if (wr_addr == LAST_ADDR) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // Decode straight from the counter, all zero when nothing is written
  always_comb begin
    node_sel = '0;
    if (wr_en) begin
      node_sel[wr_addr] = 1'b1;
    end
  end

endmodule

// ==== logic/kd_search_top.sv ====
`timescale 1ns/100ps

module kd_search_top
  import kdtree_pkg::*;
#(
  parameter int TREE_DEPTH = 6 // 1 to MAX_DEPTH
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cfg_mode,     // Host is loading the tree
  input  logic      cfg_strobe,   // One node word this cycle
  input  node_cfg_t cfg_word,
  input  logic      query_valid,
  input  query_t    query,
  output logic      result_valid, // TREE_DEPTH cycles after query_valid
  output result_t   result
);

  logic [MAX_NODES-1:0] node_sel; // Loader to node write enables

  kd_node_loader #(
    .TREE_DEPTH (TREE_DEPTH)
  ) u_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_mode   (cfg_mode),
    .cfg_strobe (cfg_strobe),
    .node_sel   (node_sel)
  );

  kd_search_tree #(
    .TREE_DEPTH (TREE_DEPTH)
  ) u_tree (
    .clk          (clk),
    .rst_n        (rst_n),
    .node_sel     (node_sel),
    .cfg          (cfg_word), // Config is broadcast, node_sel picks the target
    .query_valid  (query_valid),
    .query        (query),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// ==== logic/kd_search_tree.sv ====
`timescale 1ns/100ps

module kd_search_tree
  import kdtree_pkg::*;
#(
  parameter int TREE_DEPTH = 6
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [MAX_NODES-1:0] node_sel,
  input  node_cfg_t            cfg,
  input  logic                 query_valid,
  input  query_t               query,
  output logic                 result_valid,
  output result_t              result
);

  localparam int LEAVES = 2**TREE_DEPTH;

  // Per-level buses, entry i feeds level i, entry TREE_DEPTH is the leaf row
  query_t            patch_pipe [0:TREE_DEPTH];
  logic [LEAVES-1:0] valid_a    [0:TREE_DEPTH]; // Only the low 2^i bits carry data
  logic [LEAVES-1:0] valid_b    [0:TREE_DEPTH];

  // One-hot to binary by OR-ing the indices of set bits
  function automatic leaf_idx_t encode_leaf(input logic [LEAVES-1:0] onehot);
    leaf_idx_t idx;
    idx = '0;
    for (int k = 0; k < LEAVES; k++) begin
      if (onehot[k]) begin
        idx = idx | leaf_idx_t'(k);
      end
    end
    return idx;
  endfunction

  // Root sees the query on both lanes
  assign patch_pipe[0]    = query;
  assign valid_a[0][0]    = query_valid;
  assign valid_b[0][0]    = query_valid;

  for (genvar i = 0; i < TREE_DEPTH; i++) begin : g_level
    localparam int W_IN  = 2**i;
    localparam int W_OUT = 2**(i + 1);

    // Tie off the unused top of each level's slot
    if (W_IN < LEAVES) begin : g_pad
      assign valid_a[i][LEAVES-1:W_IN] = '0;
      assign valid_b[i][LEAVES-1:W_IN] = '0;
    end

    kd_tree_level #(
      .LEVEL      (i),
      .TREE_DEPTH (TREE_DEPTH)
    ) u_level (
      .clk          (clk),
      .rst_n        (rst_n),
      .node_sel     (node_sel),
      .cfg          (cfg),
      .patches_in   (patch_pipe[i]),
      .valids_in_a  (valid_a[i][W_IN-1:0]),
      .valids_in_b  (valid_b[i][W_IN-1:0]),
      .patches_out  (patch_pipe[i + 1]),
      .valids_out_a (valid_a[i + 1][W_OUT-1:0]),
      .valids_out_b (valid_b[i + 1][W_OUT-1:0])
    );
  end

  // Final row is full width, one bit per leaf
  assign result_valid  = |valid_a[TREE_DEPTH]; // Both lanes share the query valid
  assign result.leaf_a = encode_leaf(valid_a[TREE_DEPTH]);
  assign result.leaf_b = encode_leaf(valid_b[TREE_DEPTH]);

endmodule

// ==== logic/kd_tree_level.sv ====
`timescale 1ns/100ps

module kd_tree_level
  import kdtree_pkg::*;
#(
  parameter int LEVEL      = 0,
  parameter int TREE_DEPTH = 6
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [MAX_NODES-1:0]    node_sel,
  input  node_cfg_t               cfg,
  input  query_t                  patches_in,
  input  logic [2**LEVEL-1:0]     valids_in_a,
  input  logic [2**LEVEL-1:0]     valids_in_b,
  output query_t                  patches_out,
  output logic [2**(LEVEL+1)-1:0] valids_out_a,
  output logic [2**(LEVEL+1)-1:0] valids_out_b
);

  localparam int NODES     = 2**LEVEL;
  localparam int BASE_ADDR = NODES - 1; // Breadth-first address of node 0 here

  // Nothing below the deepest level reads the patches
  localparam bit KEEP_PATCHES = (LEVEL < TREE_DEPTH - 1);

  logic [2*NODES-1:0] child_a; // Child valids before the register
  logic [2*NODES-1:0] child_b;

  for (genvar j = 0; j < NODES; j++) begin : g_node
    kd_node u_node (
      .clk     (clk),
      .rst_n   (rst_n),
      .wen     (node_sel[BASE_ADDR + j]),
      .cfg     (cfg),
      .patches (patches_in),
      .valid_a (valids_in_a[j]),
      .valid_b (valids_in_b[j]),
      .left_a  (child_a[2*j]),     // Left child is 2j
      .right_a (child_a[2*j + 1]), // Right child is 2j+1
      .left_b  (child_b[2*j]),
      .right_b (child_b[2*j + 1])
    );
  end

  // Valid pipeline stage, cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valids_out_a <= '0;
      valids_out_b <= '0;
    end else begin
      valids_out_a <= child_a;
      valids_out_b <= child_b;
    end
  end

  // Patch pipeline stage, payload only
  if (KEEP_PATCHES) begin : g_patch_reg
    always_ff @(posedge clk) begin
      patches_out <= patches_in;
    end
  end else begin : g_patch_none
    assign patches_out = '0; // Last level, the encoder needs valids only
  end

endmodule

// ==== logic/kdtree_pkg.sv ====
package kdtree_pkg;

  // Patch geometry
  localparam int NUM_DIMS    = 5;
  localparam int COORD_WIDTH = 11;
  localparam int PATCH_WIDTH = NUM_DIMS * COORD_WIDTH; // 55 bits per patch

  // Deepest tree the address space supports
  localparam int MAX_DEPTH = 6;
  localparam int MAX_NODES = 2**MAX_DEPTH - 1; // 63 internal nodes

  // Scalar types
  typedef logic signed [COORD_WIDTH-1:0] coord_t; // Coordinate or median
  typedef logic [2:0]                    dim_t;   // Split dimension, 5..7 invalid
  typedef logic [PATCH_WIDTH-1:0]        patch_t; // Dim 0 sits in bits [10:0]
  typedef logic [MAX_DEPTH-1:0]          node_addr_t;
  typedef logic [MAX_DEPTH-1:0]          leaf_idx_t;

  // Reset value of a node split, steers every query to the right child
  localparam dim_t DIM_INVALID = 3'd7;

  // Node configuration word as it arrives on the config port
  typedef struct packed {
    coord_t                 median;    // Upper 11 bits
    logic [COORD_WIDTH-1:0] dim_field; // Lower 11 bits, only [2:0] kept
  } node_cfg_t;

  // Two patches searched side by side
  typedef struct packed {
    patch_t patch_a;
    patch_t patch_b;
  } query_t;

  // Leaf reached by each lane
  typedef struct packed {
    leaf_idx_t leaf_a;
    leaf_idx_t leaf_b;
  } result_t;

endpackage

// ==== project.f ====
logic/kdtree_pkg.sv
logic/kd_node.sv
logic/kd_node_loader.sv
logic/kd_tree_level.sv
logic/kd_search_tree.sv
logic/kd_search_top.sv
verification/kd_search_checker.sv
verification/kd_search_tb.sv

// ==== verification/kd_search_cases.txt ====
# Records: L dim_field median | I idle_cycles | Q name a0 a1 a2 a3 a4 b0 b1 b2 b3 b4 leaf_a leaf_b
# Coordinates and medians in signed decimal, leaf_a and leaf_b are the expected leaves
# Unloaded tree sends every query right down to leaf 63
Q reset_zero_neg 0 0 0 0 0 -1 -1 -1 -1 -1 63 63
Q reset_extremes -1000 -1000 -1000 -1000 -1000 1000 1000 1000 1000 1000 63 63
Q reset_mixed 5 -100 30 0 200 -30 20 -50 45 -7 63 63
I 2
# Tree A, level i splits on dim i mod 5 with median 16*j - 8*(2^i - 1)
L 0 0
L 1 -8 L 1 8
L 2 -24 L 2 -8 L 2 8 L 2 24
# Level 3 dim field 11 keeps only its low bits, dim 3
L 11 -56 L 11 -40 L 11 -24 L 11 -8 L 11 8 L 11 24 L 11 40 L 11 56
L 4 -120 L 4 -104 L 4 -88 L 4 -72 L 4 -56 L 4 -40 L 4 -24 L 4 -8
L 4 8 L 4 24 L 4 40 L 4 56 L 4 72 L 4 88 L 4 104 L 4 120
L 0 -248 L 0 -232 L 0 -216 L 0 -200 L 0 -184 L 0 -168 L 0 -152 L 0 -136
L 0 -120 L 0 -104 L 0 -88 L 0 -72 L 0 -56 L 0 -40 L 0 -24 L 0 -8
L 0 8 L 0 24 L 0 40 L 0 56 L 0 72 L 0 88 L 0 104 L 0 120
L 0 136 L 0 152 L 0 168 L 0 184 L 0 200 L 0 216 L 0 232 L 0 248
Q a_zero_neg 0 0 0 0 0 -1 -1 -1 -1 -1 32 31
Q a_extremes 1000 1000 1000 1000 1000 -1000 -1000 -1000 -1000 -1000 63 0
Q a_mixed 5 -100 30 0 200 -30 20 -50 45 -7 42 23
Q a_equal_pos 0 8 8 8 8 0 7 8 8 8 48 40
Q a_equal_neg -1 -8 -8 -8 -8 -1 -9 -8 -8 -8 31 15
Q a_limits 1023 -1024 1023 -1024 1023 -1024 1023 -1024 1023 -1024 43 20
I 3
Q a_after_gap 5 -100 30 0 200 0 0 0 0 0 42 32
I 8
# Tree B after the address wrap, dims 5 to 7 compare the value zero
L 5 1
L 6 -1 L 6 -1
L 7 0 L 7 0 L 7 0 L 7 0
L 4 10 L 4 10 L 4 10 L 4 10 L 4 10 L 4 10 L 4 10 L 4 10
L 1 -20 L 1 -20 L 1 -20 L 1 -20 L 1 -20 L 1 -20 L 1 -20 L 1 -20
L 1 -20 L 1 -20 L 1 -20 L 1 -20 L 1 -20 L 1 -20 L 1 -20 L 1 -20
# Level 5 dim field 15 is invalid, even nodes median 2 and odd nodes median -2
L 15 2 L 15 -2 L 15 2 L 15 -2 L 15 2 L 15 -2 L 15 2 L 15 -2
L 15 2 L 15 -2 L 15 2 L 15 -2 L 15 2 L 15 -2 L 15 2 L 15 -2
L 15 2 L 15 -2 L 15 2 L 15 -2 L 15 2 L 15 -2 L 15 2 L 15 -2
L 15 2 L 15 -2 L 15 2 L 15 -2 L 15 2 L 15 -2 L 15 2 L 15 -2
Q b_zero_neg 0 0 0 0 0 -1 -1 -1 -1 -1 27 27
Q b_extremes 1000 1000 1000 1000 1000 -1000 -1000 -1000 -1000 -1000 31 24
Q b_mixed 5 -100 30 0 200 -30 20 -50 45 -7 28 27
Q b_equal_pos 0 8 8 8 8 0 7 8 8 8 27 27
Q b_edges -1 -20 -8 -8 10 -1 -21 -8 -8 9 31 24
Q b_limits 1023 -1024 1023 -1024 1023 -1024 1023 -1024 1023 -1024 28 27
I 2

// ==== verification/kd_search_checker.sv ====
`timescale 1ns/100ps

module kd_search_checker
  import kdtree_pkg::*;
#(
  parameter int TREE_DEPTH = 6,
  parameter int NAME_BYTES = 24
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push,         // Query issued this cycle
  input  logic [8*NAME_BYTES-1:0] push_name,
  input  result_t                 push_exp,     // Leaves worked out by hand
  input  logic                    result_valid,
  input  result_t                 result,
  input  logic                    drain_done,   // Stimulus over, pipeline flushed
  output int                      pass_count,
  output int                      fail_count
);

  logic [8*NAME_BYTES-1:0] name_q [$]; // Expectations in issue order
  result_t                 exp_q  [$];
  int                      due_q  [$]; // Cycle on which each result is owed
  int                      cycle   = 0;
  bit                      drained = 1'b0;

  always @(posedge clk) begin
    logic [8*NAME_BYTES-1:0] name;
    result_t                 exp;
    int                      due;
    int                      passes;
    int                      fails;
    passes = 0;
    fails  = 0;
    if (!rst_n) begin
      name_q.delete();
      exp_q.delete();
      due_q.delete();
      cycle = 0;
      pass_count <= 0;
      fail_count <= 0;
    end else begin
      if (result_valid) begin
        if (exp_q.size() == 0) begin
          $display("result_valid seen at cycle %0d with no query outstanding", cycle);
          fails++;
        end else begin
          name = name_q.pop_front(); // Oldest query owns this result
          exp  = exp_q.pop_front();
          due  = due_q.pop_front();
          if (result !== exp) begin
            $display("CHECK FAILED %0s expected leaves %0d/%0d actual %0d/%0d",
                     name, exp.leaf_a, exp.leaf_b, result.leaf_a, result.leaf_b);
            fails++;
          end else if (cycle != due) begin
            $display("CHECK FAILED %0s expected latency %0d actual %0d",
                     name, TREE_DEPTH, TREE_DEPTH + cycle - due);
            fails++;
          end else begin
            $display("PASS %0s leaves %0d/%0d", name, result.leaf_a, result.leaf_b);
            passes++;
          end
        end
      end
      if (push) begin
        name_q.push_back(push_name);
        exp_q.push_back(push_exp);
        due_q.push_back(cycle + TREE_DEPTH); // Fixed pipeline depth
      end
      if (drain_done && !drained) begin
        drained = 1'b1;
        if (exp_q.size() > 0) begin
          $display("%0d expected results never arrived", exp_q.size());
          fails++;
        end
      end
      pass_count <= pass_count + passes;
      fail_count <= fail_count + fails;
      cycle++;
    end
  end

endmodule

// ==== verification/kd_search_tb.sv ====
`timescale 1ns/100ps

module kd_search_tb
  import kdtree_pkg::*;
();

  localparam int    TREE_DEPTH   = 6;
  localparam int    NAME_BYTES   = 24;
  localparam int    RESET_CYCLES = 16;
  localparam string CASE_FILE    = "verification/kd_search_cases.txt";

  logic      clk;
  logic      rst_n;
  logic      cfg_mode;
  logic      cfg_strobe;
  node_cfg_t cfg_word;
  logic      query_valid;
  query_t    query;
  logic      result_valid;
  result_t   result;

  // Checker side
  logic                    push;
  logic [8*NAME_BYTES-1:0] push_name;
  result_t                 push_exp;
  logic                    drain_done;
  int                      pass_count;
  int                      fail_count;

  // Parsed case records, one entry per record in every queue
  byte                     rec_kind  [$]; // L load, Q query, I idle
  node_cfg_t               rec_cfg   [$];
  query_t                  rec_query [$];
  result_t                 rec_exp   [$];
  logic [8*NAME_BYTES-1:0] rec_name  [$];
  int                      rec_count [$]; // Idle cycles
  int                      total_cases = 0;
  int                      cycle_limit = 0;
  int                      cycles      = 0;

  kd_search_top #(
    .TREE_DEPTH (TREE_DEPTH)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_mode     (cfg_mode),
    .cfg_strobe   (cfg_strobe),
    .cfg_word     (cfg_word),
    .query_valid  (query_valid),
    .query        (query),
    .result_valid (result_valid),
    .result       (result)
  );

  kd_search_checker #(
    .TREE_DEPTH (TREE_DEPTH),
    .NAME_BYTES (NAME_BYTES)
  ) check_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_name    (push_name),
    .push_exp     (push_exp),
    .result_valid (result_valid),
    .result       (result),
    .drain_done   (drain_done),
    .pass_count   (pass_count),
    .fail_count   (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  // Watchdog, limit set once the case file is parsed
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout, run still going after %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  task automatic add_record(input byte kind, input node_cfg_t cfg, input query_t q,
                            input result_t exp, input logic [8*NAME_BYTES-1:0] name,
                            input int count);
    rec_kind.push_back(kind);
    rec_cfg.push_back(cfg);
    rec_query.push_back(q);
    rec_exp.push_back(exp);
    rec_name.push_back(name);
    rec_count.push_back(count);
    total_cases += count;
  endtask

  task automatic read_cases(output bit ok);
    int                      fd;
    int                      code;
    int                      val;
    int                      leaf_a;
    int                      leaf_b;
    int                      coords [2*NUM_DIMS];
    logic [8*NAME_BYTES-1:0] tok;
    logic [8*NAME_BYTES-1:0] name;
    logic [8*200-1:0]        rest;
    node_cfg_t               cfg;
    query_t                  q;
    result_t                 exp;
    ok  = 1'b0;
    cfg = '0;
    q   = '0;
    exp = '0;
    fd  = $fopen(CASE_FILE, "r");
    if (fd == 0) return;
    ok = 1'b1;
    while (!$feof(fd)) begin
      tok  = '0;
      name = '0;
      code = $fscanf(fd, " %s", tok);
      if (code != 1) break; // Trailing whitespace at end of file
      if (tok == "#") begin
        code = $fgets(rest, fd); // Skip comment text
      end else if (tok == "L") begin
        code = $fscanf(fd, " %d", val);
        cfg.dim_field = val[COORD_WIDTH-1:0];
        code = $fscanf(fd, " %d", val);
        cfg.median = coord_t'(val);
        add_record("L", cfg, '0, '0, '0, 1);
      end else if (tok == "Q") begin
        code = $fscanf(fd, " %s", name);
        for (int k = 0; k < 2*NUM_DIMS; k++) begin
          code = $fscanf(fd, " %d", val);
          coords[k] = val;
        end
        for (int k = 0; k < NUM_DIMS; k++) begin // Dim 0 in the low bits
          q.patch_a[k*COORD_WIDTH +: COORD_WIDTH] = coord_t'(coords[k]);
          q.patch_b[k*COORD_WIDTH +: COORD_WIDTH] = coord_t'(coords[NUM_DIMS + k]);
        end
        code = $fscanf(fd, " %d %d", leaf_a, leaf_b);
        exp.leaf_a = leaf_idx_t'(leaf_a);
        exp.leaf_b = leaf_idx_t'(leaf_b);
        add_record("Q", '0, q, exp, name, 1);
      end else if (tok == "I") begin
        code = $fscanf(fd, " %d", val);
        add_record("I", '0, '0, '0, '0, (val < 1) ? 1 : val);
      end else begin
        $display("Unknown record %0s in the case file", tok);
        ok = 1'b0;
        break;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_idle();
    cfg_mode    <= 1'b0;
    cfg_strobe  <= 1'b0;
    query_valid <= 1'b0;
    push        <= 1'b0;
  endtask

  task automatic run_record(input int r);
    @(posedge clk);
    case (rec_kind[r])
      "L": begin
        cfg_mode    <= 1'b1; // One node word per cycle
        cfg_strobe  <= 1'b1;
        cfg_word    <= rec_cfg[r];
        query_valid <= 1'b0;
        push        <= 1'b0;
      end
      "Q": begin
        cfg_mode    <= 1'b0;
        cfg_strobe  <= 1'b0;
        query_valid <= 1'b1;
        query       <= rec_query[r];
        push        <= 1'b1; // Checker queues the expectation
        push_name   <= rec_name[r];
        push_exp    <= rec_exp[r];
      end
      default: begin
        drive_idle();
        repeat (rec_count[r] - 1) @(posedge clk);
      end
    endcase
  endtask

  initial begin
    bit ok;
    rst_n       = 1'b0;
    cfg_mode    = 1'b0;
    cfg_strobe  = 1'b0;
    cfg_word    = '0;
    query_valid = 1'b0;
    query       = '0;
    push        = 1'b0;
    push_name   = '0;
    push_exp    = '0;
    drain_done  = 1'b0;
    read_cases(ok);
    if (!ok) begin
      $display("Case file %0s is missing or malformed", CASE_FILE);
      $display("Errors found");
      $finish;
    end else begin
      cycle_limit = RESET_CYCLES + total_cases * (TREE_DEPTH + 4);
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      for (int r = 0; r < rec_kind.size(); r++) begin
        run_record(r);
      end
      @(posedge clk);
      drive_idle();
      repeat (TREE_DEPTH + 2) @(posedge clk); // Flush the pipeline
      drain_done <= 1'b1;
      repeat (2) @(posedge clk);
      $display("Tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule
